// File: compile.f
+incdir+source
source/rdmx_pkg.sv
source/checker_pkg.sv
source/rdmx_header_parser.sv
source/fd_addr_tracker.sv
source/phase_check_fsm.sv
source/data_checker.sv
test/data_checker_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the checker testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module data_checker_tb \
    -Mdir obj_dir -o data_checker_sim \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/data_checker_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "STATUS: PASS" && exit 0 || exit 1

// File: test/data_checker_tb.sv
// Testbench for the RDMX receive-stream checker
// Stimulus table, big-endian packet builder and stream handshake tasks
// Result checks and run timeout
`timescale 1ns/1ps
`default_nettype none

`include "checker_defs.svh"

module data_checker_tb;
    import rdmx_pkg::*;
    import checker_pkg::*;

    localparam int          NUM_ROWS     = 11;
    localparam int          ROW_CYCLES   = 400;
    localparam int          CYCLE_LIMIT  = ROW_CYCLES * NUM_ROWS;
    localparam logic [31:0] SEED         = 32'h3e70_eb24;

    // Two payload beats per frame-data packet and three packets per phase
    localparam int          PACKET_BYTES = 128;
    localparam int          FD_BEATS     = PACKET_BYTES / `BEAT_BYTES;
    localparam int          FD_PER_PHASE = 3;
    localparam ip_len_t     PACKET_SIZE  = ip_len_t'(PACKET_BYTES);
    localparam ip_len_t     FD_IP_LEN    = ip_len_t'(PACKET_BYTES + `IP_OVERHEAD);
    localparam ip_len_t     FC_IP_LEN    = ip_len_t'(`FC_PAYLOAD_BYTES + `IP_OVERHEAD);
    // Region holds two packets, so the offset wraps every second packet
    localparam rdmx_addr_t  RFD_ADDR     = 64'h0000_0040_0000_0000;
    localparam rdmx_addr_t  RFD_SIZE     = 64'd256;
    localparam rdmx_addr_t  RFC_ADDR     = 64'h0000_0080_0000_1000;

    logic         clk;
    logic         resetn;
    pattern_t     pattern_tdata;
    logic         pattern_tvalid;
    logic         pattern_tready;
    beat_t        eth_tdata;
    logic         eth_tvalid;
    logic         eth_tlast;
    logic         eth_tready;
    err_vec_t     error;
    logic         all_good;
    total_count_t total_packets_rcvd;
    fc_t          expected_fc;
    pattern_t     expected_frame_pattern;
    rdmx_addr_t   expected_rdmx_addr;

    // Stimulus table with one entry per row in each array
    string        row_name   [NUM_ROWS];
    int           row_phases [NUM_ROWS];
    string        row_kind   [NUM_ROWS];
    int           row_pkt    [NUM_ROWS];
    err_vec_t     row_err    [NUM_ROWS];
    total_count_t row_total  [NUM_ROWS];
    rdmx_addr_t   row_addr   [NUM_ROWS];

    int           err_count;
    int           cycle_count = 0;
    int           pkt_idx;
    rdmx_addr_t   fd_offset;
    pattern_t     last_pattern;

    data_checker u_data_checker (
        .clk                    (clk),
        .resetn                 (resetn),
        .pattern_tdata          (pattern_tdata),
        .pattern_tvalid         (pattern_tvalid),
        .pattern_tready         (pattern_tready),
        .eth_tdata              (eth_tdata),
        .eth_tvalid             (eth_tvalid),
        .eth_tlast              (eth_tlast),
        .eth_tready             (eth_tready),
        .packet_size            (PACKET_SIZE),
        .fd_packets_per_phase   (pkt_count_t'(FD_PER_PHASE)),
        .rfd_addr               (RFD_ADDR),
        .rfd_size               (RFD_SIZE),
        .rfc_addr               (RFC_ADDR),
        .error                  (error),
        .all_good               (all_good),
        .total_packets_rcvd     (total_packets_rcvd),
        .expected_fc            (expected_fc),
        .expected_frame_pattern (expected_frame_pattern),
        .expected_rdmx_addr     (expected_rdmx_addr)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Ends a run that hangs on a stalled stream
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish in %0d cycles, %0d errors so far",
                     CYCLE_LIMIT, err_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    //============================================================
    // Packet builder
    //============================================================
    function automatic err_vec_t err_bit(input int pos);
        err_vec_t v;
        v = '0;
        v[pos] = 1'b1;
        return v;
    endfunction

    // Header byte k travels on byte lane k, and each field goes MSB first
    function automatic beat_t put_field(input beat_t b, input int offset, input int nbytes,
                                        input logic [63:0] value);
        beat_t r;
        r = b;
        for (int i = 0; i < nbytes; i++) begin
            r[8*(offset+i) +: 8] = value[8*(nbytes-1-i) +: 8];
        end
        return r;
    endfunction

    function automatic beat_t build_header(input magic_t magic, input ip_len_t ip_len,
                                           input rdmx_addr_t addr);
        beat_t h;
        h = '0;
        h = put_field(h, 16, 2, 64'(ip_len));
        h = put_field(h, 42, 2, 64'(magic));
        h = put_field(h, 44, 8, addr);
        return h;
    endfunction

    //============================================================
    // Stream and reset tasks
    //============================================================
    task automatic set_row(input int idx, input string name, input int phases,
                           input string kind, input int pkt, input err_vec_t err,
                           input total_count_t total, input rdmx_addr_t addr);
        row_name[idx]   = name;
        row_phases[idx] = phases;
        row_kind[idx]   = kind;
        row_pkt[idx]    = pkt;
        row_err[idx]    = err;
        row_total[idx]  = total;
        row_addr[idx]   = addr;
    endtask

    task automatic apply_reset(input int row);
        resetn = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        // Both streams stay stalled while reset is held
        if (pattern_tready !== 1'b0 || eth_tready !== 1'b0) begin
            $display("Mismatch %s: ready levels in reset expected 00, actual %b%b",
                     row_name[row], pattern_tready, eth_tready);
            err_count++;
        end
        resetn = 1'b1;
        pkt_idx   = 0;
        fd_offset = '0;
    endtask

    // Waits for the transfer of whichever stream is offered
    task automatic wait_handshake(input logic on_pattern);
        logic ready;
        logic done;
        done = 1'b0;
        while (!done) begin
            // Ready moves only on a rising edge, so it is settled here
            @(negedge clk);
            ready = on_pattern ? pattern_tready : eth_tready;
            @(posedge clk);
            #1;
            // A frozen checker never raises ready again and the item is dropped
            if (ready || error != '0) begin
                done = 1'b1;
            end
        end
    endtask

    task automatic send_beat(input beat_t data, input logic last);
        eth_tdata  = data;
        eth_tlast  = last;
        eth_tvalid = 1'b1;
        wait_handshake(1'b0);
        eth_tvalid = 1'b0;
        eth_tlast  = 1'b0;
    endtask

    // One phase is a pattern, the frame-data packets and then the frame counter
    task automatic run_phase(input int row, input int phase);
        beat_t      beat;
        rdmx_addr_t addr;
        magic_t     magic;
        ip_len_t    ip_len;
        fc_t        fc_val;
        logic       hit;
        logic       past_fault;
        string      kind;
        int         n_pay;
        kind = row_kind[row];
        last_pattern   = pattern_t'($urandom());
        pattern_tdata  = last_pattern;
        pattern_tvalid = 1'b1;
        wait_handshake(1'b1);
        pattern_tvalid = 1'b0;
        for (int k = 0; k < FD_PER_PHASE; k++) begin
            hit    = (pkt_idx == row_pkt[row]);
            magic  = (hit && kind == "fd_magic") ? (`RDMX_MAGIC ^ 16'h0100) : `RDMX_MAGIC;
            ip_len = (hit && kind == "fd_len") ? (FD_IP_LEN + 16'd64) : FD_IP_LEN;
            addr   = RFD_ADDR + fd_offset;
            if (hit && kind == "fd_addr") begin
                addr = addr + 64'h40;
            end
            send_beat(build_header(magic, ip_len, addr), 1'b0);
            n_pay = (hit && kind == "fd_short") ? 1 : FD_BEATS;
            for (int b = 0; b < n_pay; b++) begin
                beat = {(`AXIS_DATA_W / `PATTERN_W){last_pattern}};
                if (hit && kind == "fd_data" && b == n_pay - 1) begin
                    beat[32*5 +: 32] = ~last_pattern;
                end
                send_beat(beat, b == n_pay - 1);
            end
            // Next packet goes back to the region start when it would not fit
            if (fd_offset + rdmx_addr_t'(PACKET_SIZE) < RFD_SIZE) begin
                fd_offset = fd_offset + rdmx_addr_t'(PACKET_SIZE);
            end else begin
                fd_offset = '0;
            end
            pkt_idx++;
        end
        hit    = (pkt_idx == row_pkt[row]);
        magic  = (hit && kind == "fc_magic") ? (`RDMX_MAGIC ^ 16'h0100) : `RDMX_MAGIC;
        ip_len = (hit && kind == "fc_len") ? (FC_IP_LEN + 16'd64) : FC_IP_LEN;
        addr   = (hit && kind == "fc_addr") ? (RFC_ADDR + 64'h8) : RFC_ADDR;
        send_beat(build_header(magic, ip_len, addr), 1'b0);
        // Phase n carries frame counter n counting from one
        fc_val = fc_t'(phase + 1);
        // Counters after the fault are wrong as well and only a frozen checker ignores them
        past_fault = (row_pkt[row] >= 0) && (pkt_idx > row_pkt[row]);
        if ((hit && kind == "fc_value") || past_fault) begin
            fc_val = fc_val + 1;
        end
        n_pay = (hit && kind == "fc_long") ? 2 : 1;
        for (int b = 0; b < n_pay; b++) begin
            beat = '0;
            beat[31:0] = fc_val;
            send_beat(beat, b == n_pay - 1);
        end
        pkt_idx++;
        // The FSM is back in GET_PATTERN one edge after the last beat
        @(posedge clk);
        #1;
    endtask

    //============================================================
    // Result checks
    //============================================================
    task automatic check_row(input int row);
        logic exp_good;
        exp_good = (row_err[row] == '0);
        if (error !== row_err[row]) begin
            $display("Mismatch %s: error expected %h, actual %h",
                     row_name[row], row_err[row], error);
            err_count++;
        end
        if (all_good !== exp_good) begin
            $display("Mismatch %s: all_good expected %b, actual %b",
                     row_name[row], exp_good, all_good);
            err_count++;
        end
        if (total_packets_rcvd !== row_total[row]) begin
            $display("Mismatch %s: total_packets_rcvd expected %0d, actual %0d",
                     row_name[row], row_total[row], total_packets_rcvd);
            err_count++;
        end
        if (expected_rdmx_addr !== row_addr[row]) begin
            $display("Mismatch %s: expected_rdmx_addr expected %h, actual %h",
                     row_name[row], row_addr[row], expected_rdmx_addr);
            err_count++;
        end
        if (exp_good && expected_fc !== fc_t'(row_phases[row])) begin
            $display("Mismatch %s: expected_fc expected %0d, actual %0d",
                     row_name[row], row_phases[row], expected_fc);
            err_count++;
        end
        if (exp_good && expected_frame_pattern !== last_pattern) begin
            $display("Mismatch %s: expected_frame_pattern expected %h, actual %h",
                     row_name[row], last_pattern, expected_frame_pattern);
            err_count++;
        end
        // A finished phase leaves the FSM waiting for the next pattern
        if (exp_good && pattern_tready !== 1'b1) begin
            $display("Mismatch %s: pattern_tready expected 1, actual %b",
                     row_name[row], pattern_tready);
            err_count++;
        end
        if (exp_good && eth_tready !== 1'b0) begin
            $display("Mismatch %s: eth_tready expected 0, actual %b",
                     row_name[row], eth_tready);
            err_count++;
        end
    endtask

    initial begin
        resetn         = 1'b0;
        pattern_tdata  = '0;
        pattern_tvalid = 1'b0;
        eth_tdata      = '0;
        eth_tvalid     = 1'b0;
        eth_tlast      = 1'b0;
        err_count      = 0;
        pkt_idx        = 0;
        fd_offset      = '0;
        last_pattern   = '0;
        void'($urandom(SEED));

        // Packets are numbered across the row as FD0 FD1 FD2 FC in each phase
        set_row(0, "clean_two_phases", 2, "none", -1, '0, 64'd8, '0);
        set_row(1, "fd_bad_taddr", 2, "fd_addr", 2, err_bit(`FD_BAD_TADDR), 64'd2, RFD_ADDR);
        set_row(2, "fd_bad_magic", 2, "fd_magic", 0, err_bit(`FD_BAD_MAGIC), 64'd0, '0);
        set_row(3, "fd_bad_psize", 3, "fd_len", 1, err_bit(`FD_BAD_PSIZE), 64'd1, '0);
        set_row(4, "fc_bad_magic", 2, "fc_magic", 3, err_bit(`FC_BAD_MAGIC), 64'd3, '0);
        set_row(5, "fc_bad_psize", 2, "fc_len", 7, err_bit(`FC_BAD_PSIZE), 64'd7, '0);
        // Faults on a last beat still count that packet
        set_row(6, "fd_bad_data", 2, "fd_data", 4, err_bit(`FD_BAD), 64'd5, '0);
        set_row(7, "fd_bad_plen", 2, "fd_short", 2, err_bit(`FD_BAD_PLEN), 64'd3, '0);
        set_row(8, "fc_bad_plen", 2, "fc_long", 3, err_bit(`FC_BAD_PLEN), 64'd4, '0);
        set_row(9, "fc_bad_value", 2, "fc_value", 7, err_bit(`FC_BAD), 64'd8, '0);
        set_row(10, "fc_bad_taddr", 2, "fc_addr", 3, err_bit(`FC_BAD_TADDR), 64'd3, RFC_ADDR);

        for (int row = 0; row < NUM_ROWS; row++) begin
            apply_reset(row);
            for (int ph = 0; ph < row_phases[row]; ph++) begin
                run_phase(row, ph);
            end
            // An error shows two edges after its beat is accepted
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_row(row);
        end

        $display("Finished %0d rows with %0d errors", NUM_ROWS, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/data_checker.sv
// Top level of the RDMX receive-stream checker
// Header parser, frame-data address tracker and phase FSM
`timescale 1ns/1ps
`default_nettype none

module data_checker (
    input  logic                        clk,
    input  logic                        resetn,

    // Pattern stream, one word per phase
    input  rdmx_pkg::pattern_t          pattern_tdata,
    input  logic                        pattern_tvalid,
    output logic                        pattern_tready,

    // Ethernet stream
    input  rdmx_pkg::beat_t             eth_tdata,
    input  logic                        eth_tvalid,
    input  logic                        eth_tlast,
    output logic                        eth_tready,

    // Configuration
    input  rdmx_pkg::ip_len_t           packet_size,
    input  checker_pkg::pkt_count_t     fd_packets_per_phase,
    input  rdmx_pkg::rdmx_addr_t        rfd_addr,
    input  rdmx_pkg::rdmx_addr_t        rfd_size,
    input  rdmx_pkg::rdmx_addr_t        rfc_addr,

    // Status
    output checker_pkg::err_vec_t       error,
    output logic                        all_good,
    output checker_pkg::total_count_t   total_packets_rcvd,
    output rdmx_pkg::fc_t               expected_fc,
    output rdmx_pkg::pattern_t          expected_frame_pattern,
    output rdmx_pkg::rdmx_addr_t        expected_rdmx_addr
);
    import rdmx_pkg::*;

    logic       eth_accept;
    logic       beat_valid;
    logic       beat_last;
    beat_t      beat_data;
    ip_len_t    beat_ip_len;
    magic_t     beat_magic;
    rdmx_addr_t beat_addr;
    fc_t        beat_fc;
    logic       fd_advance;
    rdmx_addr_t expected_fd_addr;

    // A beat transfers on an edge where both valid and ready are high
    assign eth_accept = eth_tvalid & eth_tready;

    rdmx_header_parser u_parser (
        .clk         (clk),
        .resetn      (resetn),
        .eth_tdata   (eth_tdata),
        .eth_accept  (eth_accept),
        .eth_tlast   (eth_tlast),
        .beat_valid  (beat_valid),
        .beat_last   (beat_last),
        .beat_data   (beat_data),
        .beat_ip_len (beat_ip_len),
        .beat_magic  (beat_magic),
        .beat_addr   (beat_addr),
        .beat_fc     (beat_fc)
    );

    fd_addr_tracker u_addr (
        .clk              (clk),
        .resetn           (resetn),
        .fd_advance       (fd_advance),
        .packet_size      (packet_size),
        .rfd_addr         (rfd_addr),
        .rfd_size         (rfd_size),
        .expected_fd_addr (expected_fd_addr)
    );

    phase_check_fsm u_fsm (
        .clk                    (clk),
        .resetn                 (resetn),
        .pattern_tdata          (pattern_tdata),
        .pattern_tvalid         (pattern_tvalid),
        .pattern_tready         (pattern_tready),
        .eth_tready             (eth_tready),
        .beat_valid             (beat_valid),
        .beat_last              (beat_last),
        .beat_data              (beat_data),
        .beat_ip_len            (beat_ip_len),
        .beat_magic             (beat_magic),
        .beat_addr              (beat_addr),
        .beat_fc                (beat_fc),
        .packet_size            (packet_size),
        .fd_packets_per_phase   (fd_packets_per_phase),
        .rfc_addr               (rfc_addr),
        .expected_fd_addr       (expected_fd_addr),
        .fd_advance             (fd_advance),
        .error                  (error),
        .all_good               (all_good),
        .total_packets_rcvd     (total_packets_rcvd),
        .expected_fc            (expected_fc),
        .expected_frame_pattern (expected_frame_pattern),
        .expected_rdmx_addr     (expected_rdmx_addr)
    );

endmodule

`default_nettype wire

// File: source/phase_check_fsm.sv
// Phase sequencing FSM for the RDMX receive checker
// Header, payload and beat-count checks with sticky error bits
// Packet counters and the stream ready levels
`timescale 1ns/1ps
`default_nettype none

`include "checker_defs.svh"

module phase_check_fsm (
    input  logic                        clk,
    input  logic                        resetn,
    input  rdmx_pkg::pattern_t          pattern_tdata,
    input  logic                        pattern_tvalid,
    output logic                        pattern_tready,
    output logic                        eth_tready,
    input  logic                        beat_valid,
    input  logic                        beat_last,
    input  rdmx_pkg::beat_t             beat_data,
    input  rdmx_pkg::ip_len_t           beat_ip_len,
    input  rdmx_pkg::magic_t            beat_magic,
    input  rdmx_pkg::rdmx_addr_t        beat_addr,
    input  rdmx_pkg::fc_t               beat_fc,
    input  rdmx_pkg::ip_len_t           packet_size,
    input  checker_pkg::pkt_count_t     fd_packets_per_phase,
    input  rdmx_pkg::rdmx_addr_t        rfc_addr,
    input  rdmx_pkg::rdmx_addr_t        expected_fd_addr,
    output logic                        fd_advance,
    output checker_pkg::err_vec_t       error,
    output logic                        all_good,
    output checker_pkg::total_count_t   total_packets_rcvd,
    output rdmx_pkg::fc_t               expected_fc,
    output rdmx_pkg::pattern_t          expected_frame_pattern,
    output rdmx_pkg::rdmx_addr_t        expected_rdmx_addr
);
    import rdmx_pkg::*;
    import checker_pkg::*;

    // IPv4 length of the frame-counter packet never changes
    localparam ip_len_t FC_IP_LEN = ip_len_t'(`FC_PAYLOAD_BYTES + `IP_OVERHEAD);

    fsm_state_t  state;
    logic        active;
    logic        pattern_accept;
    beat_count_t beat_count;
    pkt_count_t  fd_packet_count;
    beat_t       expected_frame_data;
    ip_len_t     fd_ip_len;
    beat_count_t fd_beats;

    //============================================================
    // Stream handshakes
    //============================================================
    // Holds both streams stalled until the first edge after reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    // Only one stream moves at a time, chosen by the state
    assign pattern_tready = active && (state == GET_PATTERN);
    assign eth_tready     = active && (state != GET_PATTERN);
    assign pattern_accept = pattern_tvalid && pattern_tready;

    // Expected values derived from the configuration
    assign expected_frame_data = {(`AXIS_DATA_W / `PATTERN_W){expected_frame_pattern}};
    assign fd_ip_len = packet_size + ip_len_t'(`IP_OVERHEAD);
    assign fd_beats  = beat_count_t'(packet_size / ip_len_t'(`BEAT_BYTES));
    assign all_good  = (error == '0);

    //============================================================
    // Phase sequencer and checks
    //============================================================
    always_ff @(posedge clk) begin
        // Tracker strobe is high for one cycle per frame-data header
        fd_advance <= 1'b0;

        if (!resetn) begin
            state              <= GET_PATTERN;
            error              <= '0;
            total_packets_rcvd <= '0;
            expected_fc        <= '0;
            expected_rdmx_addr <= '0;
            beat_count         <= '0;
            fd_packet_count    <= '0;
        end else if (error == '0) begin
            // The faulty packet's own last beat still counts here
            if (beat_last) begin
                total_packets_rcvd <= total_packets_rcvd + total_count_t'(1);
            end
            // Header states restart this at one
            if (beat_valid) begin
                beat_count <= beat_count + beat_count_t'(1);
            end

            case (state)
                GET_PATTERN: begin
                    if (pattern_accept) begin
                        expected_frame_pattern <= pattern_tdata;
                        fd_packet_count        <= '0;
                        state                  <= GET_FD_HEADER;
                    end
                end

                GET_FD_HEADER: begin
                    if (beat_valid) begin
                        if (beat_magic != `RDMX_MAGIC) begin
                            error[`FD_BAD_MAGIC] <= 1'b1;
                        end
                        if (beat_ip_len != fd_ip_len) begin
                            error[`FD_BAD_PSIZE] <= 1'b1;
                        end
                        if (beat_addr != expected_fd_addr) begin
                            error[`FD_BAD_TADDR] <= 1'b1;
                            expected_rdmx_addr   <= expected_fd_addr;
                        end
                        fd_advance      <= 1'b1;
                        fd_packet_count <= fd_packet_count + pkt_count_t'(1);
                        beat_count      <= beat_count_t'(1);
                        state           <= GET_FD_PAYLOAD;
                    end
                end

                GET_FD_PAYLOAD: begin
                    if (beat_valid) begin
                        if (beat_data != expected_frame_data) begin
                            error[`FD_BAD] <= 1'b1;
                        end
                        if (beat_last) begin
                            if (beat_count != fd_beats) begin
                                error[`FD_BAD_PLEN] <= 1'b1;
                            end
                            // The header count already includes this packet
                            if (fd_packet_count == fd_packets_per_phase) begin
                                state <= GET_FC_HEADER;
                            end else begin
                                state <= GET_FD_HEADER;
                            end
                        end
                    end
                end

                GET_FC_HEADER: begin
                    if (beat_valid) begin
                        if (beat_magic != `RDMX_MAGIC) begin
                            error[`FC_BAD_MAGIC] <= 1'b1;
                        end
                        if (beat_ip_len != FC_IP_LEN) begin
                            error[`FC_BAD_PSIZE] <= 1'b1;
                        end
                        if (beat_addr != rfc_addr) begin
                            error[`FC_BAD_TADDR] <= 1'b1;
                            expected_rdmx_addr   <= rfc_addr;
                        end
                        // Phase n carries frame counter n
                        expected_fc <= expected_fc + fc_t'(1);
                        beat_count  <= beat_count_t'(1);
                        state       <= GET_FC_PAYLOAD;
                    end
                end

                GET_FC_PAYLOAD: begin
                    if (beat_valid) begin
                        if (beat_fc != expected_fc) begin
                            error[`FC_BAD] <= 1'b1;
                        end
                        if (beat_last) begin
                            if (beat_count != beat_count_t'(1)) begin
                                error[`FC_BAD_PLEN] <= 1'b1;
                            end
                            state <= GET_PATTERN;
                        end
                    end
                end

                default: begin
                    state <= GET_PATTERN;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/fd_addr_tracker.sv
// Frame-data address offset tracker
// Offset advances by the packet size and wraps at the region size
`timescale 1ns/1ps
`default_nettype none

module fd_addr_tracker (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 fd_advance,
    input  rdmx_pkg::ip_len_t    packet_size,
    input  rdmx_pkg::rdmx_addr_t rfd_addr,
    input  rdmx_pkg::rdmx_addr_t rfd_size,
    output rdmx_pkg::rdmx_addr_t expected_fd_addr
);
    import rdmx_pkg::*;

    // Offset of the next frame-data packet within the region
    rdmx_addr_t fd_offs;

    // Offset after this packet if the region does not wrap
    rdmx_addr_t next_offs;

    assign next_offs = fd_offs + rdmx_addr_t'(packet_size);

    // Target address that the next frame-data header must carry
    assign expected_fd_addr = rfd_addr + fd_offs;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fd_offs <= '0;
        end else if (fd_advance) begin
            // Back to the start of the region once the packet would not fit
            if (next_offs < rfd_size) begin
                fd_offs <= next_offs;
            end else begin
                fd_offs <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rdmx_header_parser.sv
// Ethernet beat register stage
// Byte reversal and big-endian header field extraction
`timescale 1ns/1ps
`default_nettype none

`include "checker_defs.svh"

module rdmx_header_parser (
    input  logic                 clk,
    input  logic                 resetn,
    input  rdmx_pkg::beat_t      eth_tdata,
    input  logic                 eth_accept,
    input  logic                 eth_tlast,
    output logic                 beat_valid,
    output logic                 beat_last,
    output rdmx_pkg::beat_t      beat_data,
    output rdmx_pkg::ip_len_t    beat_ip_len,
    output rdmx_pkg::magic_t     beat_magic,
    output rdmx_pkg::rdmx_addr_t beat_addr,
    output rdmx_pkg::fc_t        beat_fc
);
    import rdmx_pkg::*;

    // Beat with byte 0 moved to the top, so header fields read big-endian
    beat_t be_data;

    always_comb begin
        for (int i = 0; i < `BEAT_BYTES; i++) begin
            be_data[8*i +: 8] = eth_tdata[8*(`BEAT_BYTES-1-i) +: 8];
        end
    end

    // Strobes last exactly one cycle per accepted beat
    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_valid <= 1'b0;
            beat_last  <= 1'b0;
        end else begin
            beat_valid <= eth_accept;
            beat_last  <= eth_accept & eth_tlast;
        end
    end

    //============================================================
    // Field capture. Byte k of the header sits at bit 511-8k
    //============================================================
    always_ff @(posedge clk) begin
        if (eth_accept) begin
            beat_data   <= eth_tdata;
            // IPv4 total length, bytes 16 and 17
            beat_ip_len <= be_data[`AXIS_DATA_W-1-8*16 -: 16];
            // RDMX magic, bytes 42 and 43
            beat_magic  <= be_data[`AXIS_DATA_W-1-8*42 -: 16];
            // RDMX target address, bytes 44 through 51
            beat_addr   <= be_data[`AXIS_DATA_W-1-8*44 -: `RDMX_ADDR_W];
            // The counter sits in the low word of the raw beat
            beat_fc     <= eth_tdata[31:0];
        end
    end

endmodule

`default_nettype wire

// File: source/checker_pkg.sv
// Checker state types
// FSM state enum, error vector and counter widths
`default_nettype none

`include "checker_defs.svh"

package checker_pkg;

    // Phase sequence: pattern, frame-data packets, then the frame counter
    typedef enum logic [2:0] {
        GET_PATTERN,
        GET_FD_HEADER,
        GET_FD_PAYLOAD,
        GET_FC_HEADER,
        GET_FC_PAYLOAD
    } fsm_state_t;

    // Sticky error bits, one per kind of fault
    typedef logic [`ERR_W-1:0] err_vec_t;

    // Beats seen so far in the current packet
    typedef logic [7:0] beat_count_t;

    // Frame-data packets seen so far in the current phase
    typedef logic [31:0] pkt_count_t;

    // Packets completed since reset
    typedef logic [63:0] total_count_t;

endpackage

`default_nettype wire

// File: source/rdmx_pkg.sv
// Wire-format types of the RDMX receive stream
// Beat, pattern, header field and frame-counter vectors
`default_nettype none

`include "checker_defs.svh"

package rdmx_pkg;

    // One beat of the Ethernet stream
    typedef logic [`AXIS_DATA_W-1:0] beat_t;

    // Frame-data pattern, replicated across every payload beat
    typedef logic [`PATTERN_W-1:0] pattern_t;

    // IPv4 total length, also used for the frame-data packet size
    typedef logic [15:0] ip_len_t;

    // RDMX magic number field
    typedef logic [15:0] magic_t;

    // RDMX target address
    typedef logic [`RDMX_ADDR_W-1:0] rdmx_addr_t;

    // Frame counter carried by the last packet of a phase
    typedef logic [31:0] fc_t;

endpackage

`default_nettype wire

// File: source/checker_defs.svh
// Bus widths for the pattern, Ethernet and address paths
// RDMX magic number and the IPv4 length overheads
// Bit positions of the sticky error vector
`ifndef CHECKER_DEFS_SVH
`define CHECKER_DEFS_SVH

// Ethernet stream beat, in bits and in bytes
`define AXIS_DATA_W       512
`define BEAT_BYTES        64

// Frame-data pattern and RDMX target address widths
`define PATTERN_W         32
`define RDMX_ADDR_W       64

// Every RDMX packet carries this value in its header
`define RDMX_MAGIC        16'h0122

// IPv4 length is the payload size plus this many header bytes
`define IP_OVERHEAD       50
`define FC_PAYLOAD_BYTES  4

// Error vector, frame-data bits first, then frame-counter bits
`define ERR_W             10
`define FD_BAD_MAGIC      0
`define FD_BAD_PSIZE      1
`define FD_BAD_TADDR      2
`define FD_BAD            3
`define FD_BAD_PLEN       4
`define FC_BAD_MAGIC      5
`define FC_BAD_PSIZE      6
`define FC_BAD_TADDR      7
`define FC_BAD            8
`define FC_BAD_PLEN       9

`endif
